//--- include/stream_mem_consts.svh
`ifndef STREAM_MEM_CONSTS_SVH
`define STREAM_MEM_CONSTS_SVH

// --------------------
// bus and stream widths
// --------------------
`define SM_DATA_W       128
`define SM_ADDR_W       32
`define SM_ID_W         8
`define SM_LEN_W        8
// header length field, beats minus one
`define SM_TOTAL_W      28

// burst limit in beats, 256 x 16 bytes keeps a burst inside 4 KB
`define SM_MAX_BURST    256
// bytes moved per 128-bit beat
`define SM_BEAT_BYTES   16

// --------------------
// header word layout
// --------------------
`define SM_HDR_RST_BIT  0
`define SM_HDR_LEN_MSB  31
`define SM_HDR_LEN_LSB  4
`define SM_HDR_ADDR_LSB 32
`define SM_HDR_CMD_MSB  127
`define SM_HDR_CMD_LSB  125

`endif

//--- source/stream_mem_pkg.sv
`default_nettype none

`include "stream_mem_consts.svh"

package stream_mem_pkg;

    // plain vectors for the widths that carry a meaning
    typedef logic [`SM_DATA_W-1:0]  stream_word_t;
    typedef logic [`SM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [`SM_ID_W-1:0]    mem_id_t;
    typedef logic [`SM_LEN_W-1:0]   burst_len_t;
    typedef logic [`SM_TOTAL_W-1:0] total_beats_t;

    // command field of the header word
    typedef enum logic [2:0] {
        CMD_READ       = 3'd0,
        CMD_DDR3_RESET = 3'd2,
        CMD_STATUS     = 3'd3,
        CMD_WRITE      = 3'd4
    } stream_cmd_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_ADDR,
        ST_WRITE_DATA,
        ST_READ_ADDR,
        ST_STATUS
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/ctrl_fsm.sv
`default_nettype none

`include "stream_mem_consts.svh"

module ctrl_fsm
    import stream_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_q,
    input  wire logic    si_valid,
    input  stream_word_t si_data,
    input  wire logic    so_ready,
    input  wire logic    aw_ready,
    input  wire logic    w_ready,
    input  wire logic    ar_ready,
    input  wire logic    last_burst,
    input  burst_len_t   burst_len,
    output logic         si_ready,
    output logic         aw_valid,
    output logic         w_valid,
    output logic         w_last,
    output logic         ar_valid,
    output logic         hdr_load,
    output logic         burst_next,
    output logic         ddr3_load,
    output logic         status_active
);

    ctrl_state_t        state;
    ctrl_state_t        state_nxt;
    stream_cmd_t        hdr_cmd;
    logic [`SM_LEN_W:0] beat_cnt;
    logic               aw_fire;
    logic               w_fire;
    logic               ar_fire;

    // command field, only meaningful while a header is offered in idle
    assign hdr_cmd = stream_cmd_t'(si_data[`SM_HDR_CMD_MSB:`SM_HDR_CMD_LSB]);

    assign aw_fire = aw_valid & aw_ready;
    assign w_fire  = w_valid & w_ready;
    assign ar_fire = ar_valid & ar_ready;

    // every accepted header reloads the splitter, harmless for non-transfer commands
    assign hdr_load      = (state == ST_IDLE) & si_valid;
    assign ddr3_load     = hdr_load & (hdr_cmd == CMD_DDR3_RESET);
    assign status_active = (state == ST_STATUS);

    // last beat of the burst, only flagged alongside a valid beat
    assign w_last = w_valid & (beat_cnt == 1);

    // --------------------
    // state register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst_q) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // beats left in the current write burst
    always_ff @(posedge clk) begin
        if (rst_q) begin
            beat_cnt <= '0;
        end else if (aw_fire) begin
            beat_cnt <= {1'b0, burst_len} + 1'b1;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    // --------------------
    // next state and handshakes
    // --------------------
    always_comb begin
        state_nxt  = state;
        si_ready   = 1'b0;
        aw_valid   = 1'b0;
        w_valid    = 1'b0;
        ar_valid   = 1'b0;
        burst_next = 1'b0;
        case (state)
            ST_IDLE: begin
                // header taken the cycle it shows up
                si_ready = si_valid;
                if (si_valid) begin
                    case (hdr_cmd)
                        CMD_WRITE:  state_nxt = ST_WRITE_ADDR;
                        CMD_READ:   state_nxt = ST_READ_ADDR;
                        CMD_STATUS: state_nxt = ST_STATUS;
                        // ddr3 reset and unknown codes stay idle
                        default:    state_nxt = ST_IDLE;
                    endcase
                end
            end
            ST_WRITE_ADDR: begin
                aw_valid = 1'b1;
                if (aw_ready) begin
                    state_nxt = ST_WRITE_DATA;
                end
            end
            ST_WRITE_DATA: begin
                // stream words go straight onto the write data channel
                w_valid  = si_valid;
                si_ready = si_valid & w_ready;
                if (w_fire && beat_cnt == 1) begin
                    if (last_burst) begin
                        state_nxt = ST_IDLE;
                    end else begin
                        burst_next = 1'b1;
                        state_nxt  = ST_WRITE_ADDR;
                    end
                end
            end
            ST_READ_ADDR: begin
                // issue every read burst back to back, data returns on its own
                ar_valid = 1'b1;
                if (ar_fire) begin
                    if (last_burst) begin
                        state_nxt = ST_IDLE;
                    end else begin
                        burst_next = 1'b1;
                    end
                end
            end
            ST_STATUS: begin
                // status word shown by stream_return until taken
                if (so_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/burst_splitter.sv
`default_nettype none

`include "stream_mem_consts.svh"

module burst_splitter
    import stream_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_q,
    input  stream_word_t si_data,
    input  wire logic    hdr_load,
    input  wire logic    burst_next,
    output mem_addr_t    burst_addr,
    output burst_len_t   burst_len,
    output mem_id_t      burst_id,
    output logic         last_burst
);

    localparam total_beats_t MAX_BEATS = total_beats_t'(`SM_MAX_BURST);
    localparam total_beats_t FULL_LEN  = total_beats_t'(`SM_MAX_BURST - 1);

    total_beats_t hdr_total;
    mem_addr_t    hdr_addr;
    total_beats_t remain;
    mem_addr_t    burst_step;
    logic         hdr_long;
    logic         remain_long;

    // header fields
    assign hdr_total = si_data[`SM_HDR_LEN_MSB:`SM_HDR_LEN_LSB];
    assign hdr_addr  = si_data[`SM_HDR_ADDR_LSB +: `SM_ADDR_W];

    // transfer needs more than one burst
    assign hdr_long    = (hdr_total >= FULL_LEN);
    assign remain_long = (remain > MAX_BEATS);

    // byte distance covered by the current burst
    assign burst_step = (mem_addr_t'(burst_len) + mem_addr_t'(1))
                        * mem_addr_t'(`SM_BEAT_BYTES);

    assign last_burst = (remain == '0);

    // --------------------
    // remaining beats and ID
    // --------------------
    always_ff @(posedge clk) begin
        if (rst_q) begin
            remain   <= '0;
            burst_id <= '0;
        end else if (hdr_load) begin
            burst_id <= '0;
            remain   <= hdr_long ? hdr_total - FULL_LEN : '0;
        end else if (burst_next) begin
            burst_id <= burst_id + 1'b1;
            remain   <= remain_long ? remain - MAX_BEATS : '0;
        end
    end

    // address and length of the burst on offer
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            burst_addr <= hdr_addr;
            burst_len  <= hdr_long ? burst_len_t'(FULL_LEN) : burst_len_t'(hdr_total);
        end else if (burst_next) begin
            burst_addr <= burst_addr + burst_step;
            // tail burst takes whatever is left
            burst_len  <= remain_long ? burst_len_t'(FULL_LEN)
                                      : burst_len_t'(remain - 1'b1);
        end
    end

endmodule

`default_nettype wire

//--- source/stream_return.sv
`default_nettype none

`include "stream_mem_consts.svh"

module stream_return
    import stream_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_q,
    input  stream_word_t si_data,
    input  wire logic    ddr3_load,
    input  wire logic    status_active,
    input  wire logic    init_cmptd,
    input  wire logic    r_valid,
    input  stream_word_t r_data,
    input  wire logic    so_ready,
    output logic         ddr3_reset,
    output logic         so_valid,
    output stream_word_t so_data,
    output logic         r_ready
);

    logic         init_q;
    stream_word_t status_word;

    // ddr3 reset line, written from bit 0 of a reset header
    always_ff @(posedge clk) begin
        if (rst_q) begin
            ddr3_reset <= 1'b0;
        end else if (ddr3_load) begin
            ddr3_reset <= si_data[`SM_HDR_RST_BIT];
        end
    end

    // calibration done comes from the memory clock side
    always_ff @(posedge clk) begin
        init_q <= init_cmptd;
    end

    // --------------------
    // output stream mux
    // --------------------
    // bit 1 calibration done, bit 0 ddr3 reset
    assign status_word = {{(`SM_DATA_W-2){1'b0}}, init_q, ddr3_reset};

    // read data flows through unless the status word holds the stream
    assign so_valid = status_active ? 1'b1 : r_valid;
    assign so_data  = status_active ? status_word : r_data;
    assign r_ready  = status_active ? 1'b0 : so_ready;

endmodule

`default_nettype wire

//--- source/stream_mem_ctrl.sv
`default_nettype none

module stream_mem_ctrl
    import stream_mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_q,

    // input stream, header word then write data
    input  wire logic   si_valid,
    output logic        si_ready,
    input  stream_word_t si_data,

    // output stream, read data or status word
    output logic        so_valid,
    input  wire logic   so_ready,
    output stream_word_t so_data,

    // write address channel
    output logic        aw_valid,
    input  wire logic   aw_ready,
    output mem_addr_t   aw_addr,
    output burst_len_t  aw_len,
    output mem_id_t     aw_id,

    // write data channel
    output logic        w_valid,
    input  wire logic   w_ready,
    output stream_word_t w_data,
    output logic        w_last,

    // read address channel
    output logic        ar_valid,
    input  wire logic   ar_ready,
    output mem_addr_t   ar_addr,
    output burst_len_t  ar_len,
    output mem_id_t     ar_id,

    // read data channel
    input  wire logic   r_valid,
    output logic        r_ready,
    input  stream_word_t r_data,

    // DDR3 side band
    output logic        ddr3_reset,
    input  wire logic   init_cmptd
);

    // --------------------
    // internal links
    // --------------------
    logic       hdr_load;
    logic       burst_next;
    logic       ddr3_load;
    logic       status_active;
    logic       last_burst;
    mem_addr_t  burst_addr;
    burst_len_t burst_len;
    mem_id_t    burst_id;

    // only one transfer runs at a time so both address channels share the splitter
    assign aw_addr = burst_addr;
    assign aw_len  = burst_len;
    assign aw_id   = burst_id;
    assign ar_addr = burst_addr;
    assign ar_len  = burst_len;
    assign ar_id   = burst_id;

    // bus data width equals stream width
    assign w_data = si_data;

    ctrl_fsm u_ctrl_fsm (
        .clk           (clk),
        .rst_q         (rst_q),
        .si_valid      (si_valid),
        .si_data       (si_data),
        .so_ready      (so_ready),
        .aw_ready      (aw_ready),
        .w_ready       (w_ready),
        .ar_ready      (ar_ready),
        .last_burst    (last_burst),
        .burst_len     (burst_len),
        .si_ready      (si_ready),
        .aw_valid      (aw_valid),
        .w_valid       (w_valid),
        .w_last        (w_last),
        .ar_valid      (ar_valid),
        .hdr_load      (hdr_load),
        .burst_next    (burst_next),
        .ddr3_load     (ddr3_load),
        .status_active (status_active)
    );

    burst_splitter u_burst_splitter (
        .clk        (clk),
        .rst_q      (rst_q),
        .si_data    (si_data),
        .hdr_load   (hdr_load),
        .burst_next (burst_next),
        .burst_addr (burst_addr),
        .burst_len  (burst_len),
        .burst_id   (burst_id),
        .last_burst (last_burst)
    );

    stream_return u_stream_return (
        .clk           (clk),
        .rst_q         (rst_q),
        .si_data       (si_data),
        .ddr3_load     (ddr3_load),
        .status_active (status_active),
        .init_cmptd    (init_cmptd),
        .r_valid       (r_valid),
        .r_data        (r_data),
        .so_ready      (so_ready),
        .ddr3_reset    (ddr3_reset),
        .so_valid      (so_valid),
        .so_data       (so_data),
        .r_ready       (r_ready)
    );

endmodule

`default_nettype wire

//--- sim/stream_mem_asserts.sv
`default_nettype none

`include "stream_mem_consts.svh"

module stream_mem_asserts
    import stream_mem_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_q,
    input wire logic       si_valid,
    input wire logic       si_ready,
    input wire logic       aw_valid,
    input wire logic       aw_ready,
    input wire burst_len_t aw_len,
    input wire logic       ar_valid,
    input wire logic       ar_ready,
    input wire logic       so_valid,
    input wire logic       so_ready,
    input wire logic       w_valid,
    input wire logic       w_ready,
    input wire logic       w_last
);

    // beats still owed on the current write burst
    logic [`SM_LEN_W:0] beats_left;

    always_ff @(posedge clk) begin
        if (rst_q) begin
            beats_left <= '0;
        end else if (aw_valid && aw_ready) begin
            beats_left <= {1'b0, aw_len} + 1'b1;
        end else if (w_valid && w_ready) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // --------------------
    // valid held until ready
    // --------------------
    aw_held: assert property (@(posedge clk) disable iff (rst_q)
        aw_valid && !aw_ready |=> aw_valid)
        else $error("aw_valid dropped before aw_ready");

    ar_held: assert property (@(posedge clk) disable iff (rst_q)
        ar_valid && !ar_ready |=> ar_valid)
        else $error("ar_valid dropped before ar_ready");

    so_held: assert property (@(posedge clk) disable iff (rst_q)
        so_valid && !so_ready |=> so_valid)
        else $error("so_valid dropped before so_ready");

    // wlast rides only on a real beat, and exactly on the final one of the burst
    w_last_on_beat: assert property (@(posedge clk) disable iff (rst_q)
        (w_valid || w_last) |-> w_valid && (w_last == (beats_left == 1)))
        else $error("w_last does not mark the final write beat");

    // input stream never ready ahead of a word
    si_ready_follows: assert property (@(posedge clk) disable iff (rst_q)
        si_ready |-> si_valid)
        else $error("si_ready high without si_valid");

endmodule

bind stream_mem_ctrl stream_mem_asserts u_asserts (
    .clk      (clk),
    .rst_q    (rst_q),
    .si_valid (si_valid),
    .si_ready (si_ready),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_len   (aw_len),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .so_valid (so_valid),
    .so_ready (so_ready),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_last   (w_last)
);

`default_nettype wire

//--- sim/tb_mem_model.sv
`default_nettype none

module tb_mem_model
    import stream_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_q,
    input  wire logic    aw_valid,
    output logic         aw_ready,
    input  mem_addr_t    aw_addr,
    input  burst_len_t   aw_len,
    input  mem_id_t      aw_id,
    input  wire logic    w_valid,
    output logic         w_ready,
    input  stream_word_t w_data,
    input  wire logic    ar_valid,
    output logic         ar_ready,
    input  mem_addr_t    ar_addr,
    input  burst_len_t   ar_len,
    input  mem_id_t      ar_id,
    output logic         r_valid,
    input  wire logic    r_ready,
    output stream_word_t r_data
);

    // word store, index is byte address / 16 within 16 KB
    stream_word_t mem [0:1023];

    // write burst log read by the testbench
    mem_addr_t    aw_log_addr [0:15];
    burst_len_t   aw_log_len [0:15];
    mem_id_t      aw_log_id [0:15];
    int           aw_count;
    // read burst IDs in issue order
    mem_id_t      ar_log_id [0:15];
    int           ar_count;

    int           seed;
    logic [9:0]   wr_ptr;
    int unsigned  rd_q[$];

    initial seed = 45;

    // --------------------
    // write side
    // --------------------
    always @(posedge clk) begin
        if (rst_q) begin
            aw_count <= 0;
            wr_ptr   <= '0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_log_addr[aw_count[3:0]] <= aw_addr;
                aw_log_len[aw_count[3:0]]  <= aw_len;
                aw_log_id[aw_count[3:0]]   <= aw_id;
                aw_count <= aw_count + 1;
                wr_ptr   <= aw_addr[13:4];
            end
            if (w_valid && w_ready) begin
                mem[wr_ptr] <= w_data;
                wr_ptr      <= wr_ptr + 1'b1;
            end
        end
    end

    // --------------------
    // ready stalls and read side
    // --------------------
    always @(posedge clk) begin
        int unsigned base;
        int i;
        if (rst_q) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            ar_count <= 0;
            rd_q.delete();
        end else begin
            // each ready drops about one cycle in four
            aw_ready <= 2'($random(seed)) != 2'd0;
            w_ready  <= 2'($random(seed)) != 2'd0;
            ar_ready <= 2'($random(seed)) != 2'd0;
            if (ar_valid && ar_ready) begin
                base = 32'(ar_addr[13:4]);
                for (i = 0; i <= int'(ar_len); i++) begin
                    rd_q.push_back(base + i);
                end
                ar_log_id[ar_count[3:0]] <= ar_id;
                ar_count <= ar_count + 1;
            end
            // beats in order, held until taken, gaps at random
            if (!r_valid || r_ready) begin
                if (rd_q.size() > 0 && 2'($random(seed)) != 2'd0) begin
                    r_data  <= mem[10'(rd_q.pop_front())];
                    r_valid <= 1'b1;
                end else begin
                    r_valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_stream_mem_ctrl.sv
`default_nettype none

`include "stream_mem_consts.svh"

module tb_stream_mem_ctrl
    import stream_mem_pkg::*;
();

    // beats moved by all tests plus headers, and slack for random stalls
    localparam int TEST_BEATS   = 4 + 4 + 300 + 300 + 32 + 8;
    localparam int STALL_MARGIN = 10;
    localparam int TIMEOUT      = TEST_BEATS * 20 * STALL_MARGIN;

    localparam mem_addr_t ADDR_A = 32'h0000_0400;
    localparam mem_addr_t ADDR_B = 32'h0000_2000;

    logic         clk;
    logic         rst_q;
    logic         si_valid;
    logic         si_ready;
    stream_word_t si_data;
    logic         so_valid;
    logic         so_ready;
    stream_word_t so_data;
    logic         aw_valid;
    logic         aw_ready;
    mem_addr_t    aw_addr;
    burst_len_t   aw_len;
    mem_id_t      aw_id;
    logic         w_valid;
    logic         w_ready;
    stream_word_t w_data;
    logic         w_last;
    logic         ar_valid;
    logic         ar_ready;
    mem_addr_t    ar_addr;
    burst_len_t   ar_len;
    mem_id_t      ar_id;
    logic         r_valid;
    logic         r_ready;
    stream_word_t r_data;
    logic         ddr3_reset;
    logic         init_cmptd;

    int           err_count;
    int           check_count;
    int           wlast_cnt;
    int           seed;
    stream_word_t rx_q[$];

    stream_mem_ctrl dut (.*);

    tb_mem_model mem (
        .clk      (clk),
        .rst_q    (rst_q),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_len   (aw_len),
        .aw_id    (aw_id),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .ar_id    (ar_id),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

    // --------------------
    // clock, watchdog, monitors
    // --------------------
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("=== FAIL ===");
        $finish;
    end

    // last beats seen on the write data channel
    always @(posedge clk) begin
        if (rst_q) begin
            wlast_cnt <= 0;
        end else if (w_valid && w_ready && w_last) begin
            wlast_cnt <= wlast_cnt + 1;
        end
    end

    // --------------------
    // helpers
    // --------------------
    task automatic check_value(input stream_word_t got, input stream_word_t exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // header word: command, byte address, beats minus one, reset bit
    function automatic stream_word_t make_header(input logic [2:0] cmd, input mem_addr_t addr,
                                                 input int beats, input logic rst_bit);
        stream_word_t h;
        h = '0;
        h[`SM_HDR_CMD_MSB:`SM_HDR_CMD_LSB] = cmd;
        h[`SM_HDR_ADDR_LSB +: `SM_ADDR_W] = addr;
        h[`SM_HDR_LEN_MSB:`SM_HDR_LEN_LSB] = total_beats_t'(beats - 1);
        h[`SM_HDR_RST_BIT] = rst_bit;
        return h;
    endfunction

    // data pattern tagged per test so stale words show up
    function automatic stream_word_t data_word(input int tag, input int idx);
        return {tag[31:0], idx[31:0], 32'h5a5a_0000 ^ idx[31:0], ~idx[31:0]};
    endfunction

    // offer one stream word and wait for its handshake
    task automatic send_word(input stream_word_t word);
        si_valid <= 1'b1;
        si_data  <= word;
        do begin
            @(posedge clk);
        end while (!si_ready);
    endtask

    // gather n output stream words, so_ready random or steady
    task automatic collect_output(input int n, input bit random_ready);
        rx_q.delete();
        while (rx_q.size() < n) begin
            @(posedge clk);
            if (so_valid && so_ready) begin
                rx_q.push_back(so_data);
            end
            if (random_ready) begin
                so_ready <= 1'($random(seed));
            end else begin
                so_ready <= 1'b1;
            end
        end
        so_ready <= 1'b1;
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_reset_state();
        @(posedge clk);
        check_value(stream_word_t'(aw_valid), '0, "aw_valid after reset");
        check_value(stream_word_t'(w_valid), '0, "w_valid after reset");
        check_value(stream_word_t'(ar_valid), '0, "ar_valid after reset");
        check_value(stream_word_t'(so_valid), '0, "so_valid after reset");
        check_value(stream_word_t'(ddr3_reset), '0, "ddr3_reset after reset");
    endtask

    task automatic test_short_write_read();
        int i;
        int n0;
        int w0;
        n0 = mem.aw_count;
        w0 = wlast_cnt;
        send_word(make_header(CMD_WRITE, ADDR_A, 4, 1'b0));
        for (i = 0; i < 4; i++) begin
            send_word(data_word(2, i));
        end
        send_word(make_header(CMD_READ, ADDR_A, 4, 1'b0));
        si_valid <= 1'b0;
        collect_output(4, 1'b0);
        for (i = 0; i < 4; i++) begin
            check_value(rx_q[i], data_word(2, i), "short read data");
        end
        check_value(stream_word_t'(mem.aw_count - n0), 1, "short write burst count");
        check_value(stream_word_t'(mem.aw_log_len[n0]), 3, "short write burst length");
        check_value(stream_word_t'(wlast_cnt - w0), 1, "short write w_last count");
    endtask

    task automatic test_long_split();
        int i;
        int n0;
        int a0;
        int w0;
        n0 = mem.aw_count;
        a0 = mem.ar_count;
        w0 = wlast_cnt;
        send_word(make_header(CMD_WRITE, ADDR_B, 300, 1'b0));
        for (i = 0; i < 300; i++) begin
            send_word(data_word(3, i));
        end
        send_word(make_header(CMD_READ, ADDR_B, 300, 1'b0));
        si_valid <= 1'b0;
        collect_output(300, 1'b0);
        for (i = 0; i < 300; i++) begin
            check_value(rx_q[i], data_word(3, i), "long read data");
        end
        // 300 beats split as 256 then 44, second burst one 4 KB step on
        check_value(stream_word_t'(mem.aw_count - n0), 2, "long write burst count");
        check_value(stream_word_t'(mem.aw_log_addr[n0]), stream_word_t'(ADDR_B), "burst 0 addr");
        check_value(stream_word_t'(mem.aw_log_len[n0]), 255, "burst 0 length");
        check_value(stream_word_t'(mem.aw_log_id[n0]), 0, "burst 0 id");
        check_value(stream_word_t'(mem.aw_log_addr[n0 + 1]),
                    stream_word_t'(ADDR_B + 256 * `SM_BEAT_BYTES), "burst 1 addr");
        check_value(stream_word_t'(mem.aw_log_len[n0 + 1]), 43, "burst 1 length");
        check_value(stream_word_t'(mem.aw_log_id[n0 + 1]), 1, "burst 1 id");
        check_value(stream_word_t'(wlast_cnt - w0), 2, "long write w_last count");
        // read side splits the same way, IDs count up from zero
        check_value(stream_word_t'(mem.ar_count - a0), 2, "long read burst count");
        check_value(stream_word_t'(mem.ar_log_id[a0]), 0, "read burst 0 id");
        check_value(stream_word_t'(mem.ar_log_id[a0 + 1]), 1, "read burst 1 id");
    endtask

    task automatic test_ddr3_status();
        init_cmptd <= 1'b1;
        repeat (3) @(posedge clk);
        send_word(make_header(CMD_DDR3_RESET, '0, 1, 1'b1));
        si_valid <= 1'b0;
        @(posedge clk);
        check_value(stream_word_t'(ddr3_reset), 1, "ddr3_reset set");
        send_word(make_header(CMD_STATUS, '0, 1, 1'b0));
        si_valid <= 1'b0;
        collect_output(1, 1'b0);
        // bit 1 calibration done, bit 0 reset line
        check_value(rx_q[0], stream_word_t'({1'b1, 1'b1}), "status word");
        send_word(make_header(CMD_DDR3_RESET, '0, 1, 1'b0));
        si_valid <= 1'b0;
        @(posedge clk);
        check_value(stream_word_t'(ddr3_reset), 0, "ddr3_reset cleared");
        // reset line low now, calibration done still high
        send_word(make_header(CMD_STATUS, '0, 1, 1'b0));
        si_valid <= 1'b0;
        collect_output(1, 1'b0);
        check_value(rx_q[0], stream_word_t'({1'b1, 1'b0}), "status word after clear");
    endtask

    task automatic test_unknown_then_read();
        int i;
        int aw0;
        int ar0;
        aw0 = mem.aw_count;
        ar0 = mem.ar_count;
        send_word(make_header(3'd7, ADDR_B, 1, 1'b0));
        si_valid <= 1'b0;
        repeat (4) @(posedge clk);
        check_value(stream_word_t'(mem.aw_count - aw0), 0, "unknown command write activity");
        check_value(stream_word_t'(mem.ar_count - ar0), 0, "unknown command read activity");
        send_word(make_header(CMD_READ, ADDR_B, 32, 1'b0));
        si_valid <= 1'b0;
        collect_output(32, 1'b1);
        for (i = 0; i < 32; i++) begin
            check_value(rx_q[i], data_word(3, i), "stalled read data");
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_q       = 1'b1;
        si_valid    = 1'b0;
        si_data     = '0;
        so_ready    = 1'b0;
        init_cmptd  = 1'b0;
        err_count   = 0;
        check_count = 0;
        seed        = 45;
        repeat (2) @(posedge clk);
        rst_q    <= 1'b0;
        so_ready <= 1'b1;
        test_reset_state();
        test_short_write_read();
        test_long_split();
        test_ddr3_status();
        test_unknown_then_read();
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- stream_mem_ctrl.f
+incdir+include
source/stream_mem_pkg.sv
source/ctrl_fsm.sv
source/burst_splitter.sv
source/stream_return.sv
source/stream_mem_ctrl.sv
sim/stream_mem_asserts.sv
sim/tb_mem_model.sv
sim/tb_stream_mem_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f stream_mem_ctrl.f --top-module tb_stream_mem_ctrl -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1
